/* hdl/mem_stage_defs.svh */
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stage sizing.
`define MEM_FIFO_DEPTH 4 // pending operations, power of two.
`define MEM_DW 32 // data and address width.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single data transfer fields.
`define INSN_CLASS_HI 27
`define INSN_CLASS_LO 26
`define INSN_CLASS_LDRSTR 2'b01
`define INSN_I 25 // register offset form.
`define INSN_P 24 // pre-index.
`define INSN_U 23 // up.
`define INSN_B 22 // byte.
`define INSN_W 21 // writeback.
`define INSN_L 20 // load.
`define INSN_RN_HI 19
`define INSN_RN_LO 16
`define INSN_RD_HI 15
`define INSN_RD_LO 12
`define INSN_UNDEF 4 // set with I means undefined space.

`endif

/* hdl/mem_op_pkg.sv */
`include "mem_stage_defs.svh"

package mem_op_pkg;

	// transfer direction.
	typedef enum logic {
		LS_LDR,
		LS_STR
	} ls_op_e;

	// one decoded operation, as it waits in the queue.
	typedef struct packed {
		ls_op_e op;
		logic is_byte; // unsigned byte access.
		logic [3:0] rd;
		logic [3:0] rn;
		logic base_wb; // write wb_addr back to rn.
		logic [`MEM_DW-1:0] addr; // transfer address, unaligned.
		logic [`MEM_DW-1:0] wb_addr; // base plus or minus offset.
		logic [`MEM_DW-1:0] wdata; // store data.
	} mem_op_t;

endpackage

/* hdl/mem_bus_pkg.sv */
`include "mem_stage_defs.svh"

package mem_bus_pkg;

	// request towards the memory bus.
	typedef struct packed {
		logic [`MEM_DW-1:0] addr; // always word aligned.
		logic rd_req;
		logic wr_req;
		logic [`MEM_DW-1:0] wr_data;
		logic [3:0] be;
	} bus_req_t;

	// register file write port.
	typedef struct packed {
		logic valid;
		logic [3:0] regsel;
		logic [`MEM_DW-1:0] data;
	} reg_wb_t;

	// consumer sequencing.
	typedef enum logic [1:0] {
		ACC_IDLE,
		ACC_BUS,
		ACC_WB_RD,
		ACC_WB_BASE
	} access_state_e;

endpackage

/* hdl/mem_addr_gen.sv */
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module mem_addr_gen (
	input logic clk,
	input logic arst_n,
	input logic insn_valid,
	input logic [31:0] insn,
	input logic [`MEM_DW-1:0] base,
	input logic [`MEM_DW-1:0] offset,
	input logic full,
	output logic [3:0] st_read,
	input logic [`MEM_DW-1:0] st_data,
	output logic push,
	output mem_op_pkg::mem_op_t push_op
);

	logic is_ldrstr;
	logic is_load;
	logic take;
	logic [`MEM_DW-1:0] off_addr;
	logic [3:0] st_read_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode and accept.

	// class 01, minus the undefined register-offset space.
	assign is_ldrstr = (insn[`INSN_CLASS_HI:`INSN_CLASS_LO] == `INSN_CLASS_LDRSTR) &&
		!(insn[`INSN_I] && insn[`INSN_UNDEF]);
	assign is_load = insn[`INSN_L];

	assign take = insn_valid & ~full; // anything else is dropped here.
	assign push = take & is_ldrstr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address arithmetic.

	assign off_addr = insn[`INSN_U] ? base + offset : base - offset;

	always_comb begin
		push_op.op = is_load ? mem_op_pkg::LS_LDR : mem_op_pkg::LS_STR;
		push_op.is_byte = insn[`INSN_B];
		push_op.rd = insn[`INSN_RD_HI:`INSN_RD_LO];
		push_op.rn = insn[`INSN_RN_HI:`INSN_RN_LO];
		// post-indexed always updates the base.
		push_op.base_wb = insn[`INSN_W] | ~insn[`INSN_P];
		push_op.addr = insn[`INSN_P] ? off_addr : base; // pre uses offset address.
		push_op.wb_addr = off_addr;
		push_op.wdata = is_load ? '0 : st_data;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// store data read port.

	// follows rd for a store, otherwise parks on the last index
	// so the register file port does not toggle.
	assign st_read = (is_ldrstr && !is_load) ? insn[`INSN_RD_HI:`INSN_RD_LO] : st_read_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st_read_q <= '0;
		end else begin
			st_read_q <= st_read;
		end
	end

endmodule

/* hdl/mem_op_fifo.sv */
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module mem_op_fifo (
	input logic clk,
	input logic arst_n,
	input logic push,
	input mem_op_pkg::mem_op_t push_op,
	input logic pop,
	output mem_op_pkg::mem_op_t head,
	output logic full,
	output logic empty
);

	localparam int AW = $clog2(`MEM_FIFO_DEPTH);
	localparam logic [AW:0] DEPTH = `MEM_FIFO_DEPTH;

	mem_op_pkg::mem_op_t mem [`MEM_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count; // one bit wider to hold DEPTH.
	logic do_push;
	logic do_pop;

	assign full = (count == DEPTH);
	assign empty = (count == '0);

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	// storage.
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_op;
		end
	end

	assign head = mem[rd_ptr];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pointers and occupancy.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth.
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither.
			endcase
		end
	end

endmodule

/* hdl/mem_access.sv */
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module mem_access (
	input logic clk,
	input logic arst_n,
	input mem_op_pkg::mem_op_t head,
	input logic empty,
	output logic pop,
	output mem_bus_pkg::bus_req_t bus,
	input logic rw_wait,
	input logic [`MEM_DW-1:0] rd_data,
	output mem_bus_pkg::reg_wb_t wb
);

	mem_bus_pkg::access_state_e state;
	mem_op_pkg::mem_op_t cur; // operation in flight.
	logic is_load;
	logic bus_done;
	logic [4:0] rot_sh;
	logic [2*`MEM_DW-1:0] rot_dbl;
	logic [`MEM_DW-1:0] ld_val;
	logic [`MEM_DW-1:0] ld_data;

	assign is_load = (cur.op == mem_op_pkg::LS_LDR);
	assign pop = (state == mem_bus_pkg::ACC_IDLE) && !empty;
	assign bus_done = (state == mem_bus_pkg::ACC_BUS) && !rw_wait;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus request, all from registered state.
	always_comb begin
		bus.addr = {cur.addr[`MEM_DW-1:2], 2'b00};
		bus.rd_req = (state == mem_bus_pkg::ACC_BUS) && is_load;
		bus.wr_req = (state == mem_bus_pkg::ACC_BUS) && !is_load;
		// byte store goes out on every lane, be picks the one.
		bus.wr_data = cur.is_byte ? {4{cur.wdata[7:0]}} : cur.wdata;
		bus.be = cur.is_byte ? (4'b0001 << cur.addr[1:0]) : 4'b1111;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// load alignment.
	always_comb begin
		rot_sh = {cur.addr[1:0], 3'b000};
		rot_dbl = {rd_data, rd_data} >> rot_sh; // rotate right by whole bytes.
		if (cur.is_byte) begin
			ld_val = {{(`MEM_DW-8){1'b0}}, rot_dbl[7:0]};
		end else begin
			ld_val = rot_dbl[`MEM_DW-1:0];
		end
	end

	// register writeback port.
	always_comb begin
		wb.valid = (state == mem_bus_pkg::ACC_WB_RD) || (state == mem_bus_pkg::ACC_WB_BASE);
		if (state == mem_bus_pkg::ACC_WB_RD) begin
			wb.regsel = cur.rd;
			wb.data = ld_data;
		end else begin
			wb.regsel = cur.rn;
			wb.data = cur.wb_addr;
		end
	end

	// payload, no reset needed.
	always_ff @(posedge clk) begin
		if (pop) begin
			cur <= head;
		end
		if (bus_done && is_load) begin
			ld_data <= ld_val; // rd_data sampled on completion.
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// access sequencing.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= mem_bus_pkg::ACC_IDLE;
		end else begin
			case (state)
				mem_bus_pkg::ACC_IDLE: begin
					if (!empty) state <= mem_bus_pkg::ACC_BUS;
				end
				mem_bus_pkg::ACC_BUS: begin
					if (bus_done) begin
						if (is_load) state <= mem_bus_pkg::ACC_WB_RD;
						else if (cur.base_wb) state <= mem_bus_pkg::ACC_WB_BASE;
						else state <= mem_bus_pkg::ACC_IDLE; // plain store ends here.
					end
				end
				mem_bus_pkg::ACC_WB_RD: begin
					state <= cur.base_wb ? mem_bus_pkg::ACC_WB_BASE : mem_bus_pkg::ACC_IDLE;
				end
				default: state <= mem_bus_pkg::ACC_IDLE;
			endcase
		end
	end

endmodule

/* hdl/mem_stage_top.sv */
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module mem_stage_top (
	input logic clk,
	input logic arst_n,
	input logic insn_valid,
	input logic [31:0] insn,
	input logic [`MEM_DW-1:0] base,
	input logic [`MEM_DW-1:0] offset,
	output logic [3:0] st_read,
	input logic [`MEM_DW-1:0] st_data,
	output mem_bus_pkg::bus_req_t bus,
	input logic rw_wait,
	input logic [`MEM_DW-1:0] rd_data,
	output mem_bus_pkg::reg_wb_t wb,
	output logic stall
);

	logic push;
	logic pop;
	logic full;
	logic empty;
	mem_op_pkg::mem_op_t push_op;
	mem_op_pkg::mem_op_t head;

	assign stall = full; // back-pressure is queue occupancy only.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// producer, queue, consumer.
	mem_addr_gen u_addr_gen (
		.clk (clk),
		.arst_n (arst_n),
		.insn_valid (insn_valid),
		.insn (insn),
		.base (base),
		.offset (offset),
		.full (full),
		.st_read (st_read),
		.st_data (st_data),
		.push (push),
		.push_op (push_op)
	);

	mem_op_fifo u_op_fifo (
		.clk (clk),
		.arst_n (arst_n),
		.push (push),
		.push_op (push_op),
		.pop (pop),
		.head (head),
		.full (full),
		.empty (empty)
	);

	mem_access u_access (
		.clk (clk),
		.arst_n (arst_n),
		.head (head),
		.empty (empty),
		.pop (pop),
		.bus (bus),
		.rw_wait (rw_wait),
		.rd_data (rd_data),
		.wb (wb)
	);

endmodule

/* testbench/mem_stage_chk.sv */
`timescale 1ns/1ps

module mem_stage_chk (
	input logic clk,
	input logic arst_n,
	input mem_bus_pkg::bus_req_t bus,
	input logic rw_wait,
	input mem_bus_pkg::reg_wb_t wb,
	input logic stall,
	input logic push,
	input logic pop
);

	int unsigned fail_cnt = 0; // read by the testbench at the end.
	logic req;

	assign req = bus.rd_req | bus.wr_req;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus protocol.
	a_one_dir: assert property (@(posedge clk) disable iff (!arst_n)
		!(bus.rd_req && bus.wr_req))
		else begin
			fail_cnt++;
			$error("rd_req and wr_req high together");
		end

	a_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(req && rw_wait) |=> (req && $stable(bus)))
		else begin
			fail_cnt++;
			$error("bus request changed while rw_wait was high");
		end

	a_align: assert property (@(posedge clk) disable iff (!arst_n)
		req |-> (bus.addr[1:0] == 2'b00))
		else begin
			fail_cnt++;
			$error("bus address not word aligned");
		end

	// quiet outputs while in reset.
	a_reset: assert property (@(posedge clk) !arst_n |-> !(req || wb.valid))
		else begin
			fail_cnt++;
			$error("request or writeback during reset");
		end

	// stall moves with queue traffic, one entry at a time.
	a_stall_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(stall) |-> $past(push && !pop))
		else begin
			fail_cnt++;
			$error("stall rose without a push that filled the queue");
		end

	a_stall_fall: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(stall) |-> $past(pop))
		else begin
			fail_cnt++;
			$error("stall fell without a pop from the queue");
		end

endmodule

bind mem_stage_top mem_stage_chk chk (
	.clk (clk),
	.arst_n (arst_n),
	.bus (bus),
	.rw_wait (rw_wait),
	.wb (wb),
	.stall (stall),
	.push (push),
	.pop (pop)
);

/* testbench/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int N_RAND = 16;
	localparam int N_OPS = 30 + N_RAND; // directed plus random instructions.
	localparam int MEM_WORDS = 64;

	logic clk;
	logic arst_n;
	logic insn_valid;
	logic [31:0] insn;
	logic [31:0] base;
	logic [31:0] offset;
	logic [3:0] st_read;
	logic [31:0] st_data;
	mem_bus_pkg::bus_req_t bus;
	logic rw_wait;
	logic [31:0] rd_data;
	mem_bus_pkg::reg_wb_t wb;
	logic stall;

	logic [31:0] regs [16];
	logic [31:0] mem [MEM_WORDS]; // bus side memory.
	logic [31:0] ref_mem [MEM_WORDS]; // updated in program order.
	logic [3:0] exp_reg [$];
	logic [31:0] exp_data [$];
	string exp_name [$];
	string test_name;
	int errors;
	int bus_cnt;
	int exp_bus_cnt;
	int max_wait;
	int wait_left;
	bit busy;
	bit saw_stall;

	mem_stage_top dut (
		.clk (clk),
		.arst_n (arst_n),
		.insn_valid (insn_valid),
		.insn (insn),
		.base (base),
		.offset (offset),
		.st_read (st_read),
		.st_data (st_data),
		.bus (bus),
		.rw_wait (rw_wait),
		.rd_data (rd_data),
		.wb (wb),
		.stall (stall)
	);

	assign st_data = regs[st_read]; // register file read port.

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(CLK_PERIOD * (RESET_CYCLES + N_OPS * 12));
		$display("ERROR: watchdog expired, %0d writebacks still outstanding", exp_reg.size());
		$display(">>> FAIL");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers.
	function automatic logic [31:0] fill_word(input int i);
		logic [7:0] a;
		a = i[7:0];
		return {a ^ 8'hc3, a + 8'h3c, ~a, a};
	endfunction

	function automatic logic [31:0] rotate_bytes(input logic [31:0] w, input logic [1:0] sh);
		logic [31:0] r;
		r = w;
		for (int k = 0; k < int'(sh); k++) begin
			r = {r[7:0], r[31:8]}; // one byte to the right.
		end
		return r;
	endfunction

	function automatic logic [31:0] encode_ls(input logic l, b, u, p, w,
		input logic [3:0] rn, rd);
		return {4'he, 2'b01, 1'b0, p, u, b, w, l, rn, rd, 12'h000};
	endfunction

	task automatic expect_wb(input logic [3:0] r, input logic [31:0] d);
		exp_reg.push_back(r);
		exp_data.push_back(d);
		exp_name.push_back(test_name);
	endtask

	// ARM single transfer rules, applied at acceptance.
	task automatic predict(input logic [31:0] i, input logic [31:0] b, input logic [31:0] o);
		logic [31:0] off_addr;
		logic [31:0] addr;
		logic [31:0] w;
		int idx;
		if (i[27:26] == 2'b01 && !(i[25] && i[4])) begin
			off_addr = i[23] ? b + o : b - o;
			addr = i[24] ? off_addr : b; // post-index uses the base.
			idx = int'(addr[7:2]);
			exp_bus_cnt++;
			if (i[20]) begin
				w = rotate_bytes(ref_mem[idx], addr[1:0]);
				expect_wb(i[15:12], i[22] ? {24'h0, w[7:0]} : w);
			end else if (i[22]) begin
				ref_mem[idx][8*addr[1:0] +: 8] = regs[i[15:12]][7:0];
			end else begin
				ref_mem[idx] = regs[i[15:12]];
			end
			if (i[21] || !i[24]) begin
				expect_wb(i[19:16], off_addr);
			end
		end
	endtask

	// called just after a falling edge.
	task automatic send_insn(input logic [31:0] i, input logic [31:0] b, input logic [31:0] o);
		insn_valid = 1'b1;
		insn = i;
		base = b;
		offset = o;
		while (stall) begin
			saw_stall = 1'b1;
			@(negedge clk);
		end
		predict(i, b, o);
		@(negedge clk);
		insn_valid = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp == act) else begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus memory with random wait states.
	always @(negedge clk) begin
		int idx;
		idx = int'(bus.addr[7:2]);
		if (arst_n && (bus.rd_req || bus.wr_req)) begin
			if (!busy) begin
				busy = 1'b1;
				wait_left = int'($urandom % (max_wait + 1));
			end else if (wait_left > 0) begin
				wait_left--;
			end
			rw_wait = (wait_left != 0);
			rd_data = mem[idx];
			if (wait_left == 0) begin
				bus_cnt++; // completes on the next rising edge.
				for (int k = 0; k < 4; k++) begin
					if (bus.wr_req && bus.be[k]) mem[idx][8*k +: 8] = bus.wr_data[8*k +: 8];
				end
			end
		end else begin
			busy = 1'b0;
			rw_wait = 1'b0;
		end
	end

	// writebacks in program order.
	always @(negedge clk) begin
		if (arst_n && wb.valid) begin
			assert (exp_reg.size() != 0) else begin
				errors++;
				$display("ERROR: writeback to r%0d with nothing expected", wb.regsel);
			end
			if (exp_reg.size() != 0) begin
				check_value({exp_name[0], " regsel"}, {28'h0, exp_reg[0]}, {28'h0, wb.regsel});
				check_value({exp_name[0], " data"}, exp_data[0], wb.data);
				void'(exp_reg.pop_front());
				void'(exp_data.pop_front());
				void'(exp_name.pop_front());
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus.
	initial begin
		logic [31:0] r;
		void'($urandom(32'hb99b_8987));
		arst_n = 1'b1;
		insn_valid = 1'b0;
		insn = '0;
		base = '0;
		offset = '0;
		rw_wait = 1'b0;
		rd_data = '0;
		errors = 0;
		bus_cnt = 0;
		exp_bus_cnt = 0;
		max_wait = 3;
		wait_left = 0;
		busy = 1'b0;
		saw_stall = 1'b0;
		test_name = "reset";
		for (int i = 0; i < 16; i++) begin
			regs[i] = ~fill_word(i + 100);
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		#(CLK_PERIOD / 10);
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;

		test_name = "idle";
		repeat (4) @(negedge clk);
		send_insn(32'he080_1002, 32'h40, 32'h4); // data processing.
		send_insn(encode_ls(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 4'd1, 4'd2) | 32'h0200_0010,
			32'h40, 32'h4); // undefined space.
		repeat (8) @(negedge clk);
		check_value("idle bus count", 32'd0, 32'(bus_cnt));

		test_name = "word_load";
		for (int k = 0; k < 4; k++) begin
			send_insn(encode_ls(1'b1, 1'b0, 1'b1, 1'b1, k[0], 4'(k + 1), 4'(k + 5)),
				32'(16 * k + 32), 32'(4 * k));
		end

		test_name = "rot_load";
		for (int k = 1; k < 4; k++) begin
			send_insn(encode_ls(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 4'd2, 4'(k)), 32'h80, 32'(k));
		end
		for (int k = 0; k < 4; k++) begin
			send_insn(encode_ls(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 4'd2, 4'(k + 4)), 32'h90, 32'(k));
		end

		test_name = "store";
		regs[3] = 32'hdead_beef;
		for (int k = 0; k < 4; k++) begin
			regs[6 + k] = 32'h5a5a_5a00 | 32'(8'h11 * (k + 1));
		end
		send_insn(encode_ls(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 4'd1, 4'd3), 32'ha0, 32'h0);
		send_insn(encode_ls(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 4'd1, 4'd6), 32'hb0, 32'h1);
		send_insn(encode_ls(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 4'd1, 4'd7), 32'hb0, 32'h3);
		send_insn(encode_ls(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 4'd1, 4'd8), 32'hc0, 32'h0);
		send_insn(encode_ls(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 4'd1, 4'd9), 32'hc0, 32'h2);
		for (int k = 0; k < 3; k++) begin
			send_insn(encode_ls(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 4'd1, 4'd12),
				32'(32'ha0 + 16 * k), 32'h0);
		end

		// every up/down and pre/post pair, load then store.
		test_name = "index_mode";
		for (int m = 0; m < 8; m++) begin
			send_insn(encode_ls(!m[0], 1'b0, m[1], m[2], 1'b0, 4'd10, 4'd11), 32'h60, 32'h8);
		end

		test_name = "backpressure";
		max_wait = 6;
		for (int k = 0; k < N_RAND; k++) begin
			r = $urandom;
			if (!r[0]) regs[r[11:8]] = $urandom;
			send_insn(encode_ls(r[0], r[1], r[2], r[3], r[4], r[15:12], r[11:8]),
				{24'h0, r[23:16]}, {28'h0, r[27:24]});
		end
		send_insn(encode_ls(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 4'd0, 4'd15), 32'h10, 32'h0);

		while (exp_reg.size() != 0) @(negedge clk);
		check_value("bus count", 32'(exp_bus_cnt), 32'(bus_cnt));
		assert (saw_stall) else begin
			errors++;
			$display("ERROR: stall never rose under back-pressure");
		end
		$display("errors: %0d testbench, %0d assertion", errors, dut.chk.fail_cnt);
		if (errors == 0 && dut.chk.fail_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* mem_stage.f */
+incdir+hdl
hdl/mem_op_pkg.sv
hdl/mem_bus_pkg.sv
hdl/mem_addr_gen.sv
hdl/mem_op_fifo.sv
hdl/mem_access.sv
hdl/mem_stage_top.sv
testbench/mem_stage_chk.sv
testbench/mem_stage_tb.sv

/* run_mem_stage.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f mem_stage.f \
	--top-module mem_stage_tb -o mem_stage_sim \
	&& ./obj_dir/mem_stage_sim | tee sim.log \
	|| { echo "build or run failed"; exit 1; }
grep -q "^>>> PASS$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
